//--- sources.f
+incdir+verilog
verilog/hash_table_pkg.sv
verilog/hash_h3.sv
verilog/bucket_ram.sv
verilog/bucket_arbiter.sv
verilog/lookup_unit.sv
verilog/insert_unit.sv
verilog/hash_table_top.sv
verif/hash_table_properties.sv
verif/hash_table_tb.sv

//--- verif/hash_table_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "hash_table_macros.svh"

module hash_table_tb;

	localparam int clk_period = 100;
	localparam int num_tests = 6;
	localparam int cycles_per_test = 40;
	localparam int batch_ops = 16;
	localparam int max_tries = 100000;

	// Row i is folded into the index when key bit i is set
	localparam logic [`HT_IDX_W-1:0] h3_rows [`HT_KEY_W] = '{
		10'b0110110101, 10'b0000100000, 10'b0101101001, 10'b0001001100,
		10'b1001011101, 10'b0101000110, 10'b1100110001, 10'b1001111011,
		10'b0010110110, 10'b1101111111, 10'b1110101100, 10'b0001011101,
		10'b0111110010, 10'b1011111001, 10'b0011011101, 10'b1001001010,
		10'b1011000000, 10'b1010100010, 10'b0110101110, 10'b1100001111,
		10'b1000011011, 10'b1010100001, 10'b0001110110, 10'b1111111100,
		10'b0111110000, 10'b1010011111, 10'b0011010010, 10'b0011110110,
		10'b0011110000, 10'b0110010001, 10'b0111111101, 10'b0011000001,
		10'b0001101101, 10'b0011010010, 10'b0110001001, 10'b0100100010,
		10'b0111110100, 10'b1010011001, 10'b0010101000, 10'b0100001100,
		10'b1001111000, 10'b0011001001, 10'b1010111011, 10'b1110101000,
		10'b1101010010, 10'b1011110001, 10'b1000101000, 10'b0010111010,
		10'b1100101100, 10'b1010001000, 10'b1000000111, 10'b0001100001,
		10'b0000001110, 10'b1101010001, 10'b1001001011, 10'b0001000010,
		10'b0010111000, 10'b0000001000, 10'b1000010001, 10'b0001111000,
		10'b0101101000, 10'b0010101001, 10'b1110101100, 10'b0010000001
	};

	logic clk;
	logic rst;
	logic lookup_req;
	logic [`HT_KEY_W-1:0] lookup_key;
	logic lookup_busy;
	logic lookup_done;
	logic lookup_hit;
	logic [`HT_VAL_W-1:0] lookup_value;
	logic insert_req;
	logic [`HT_KEY_W-1:0] insert_key;
	logic [`HT_VAL_W-1:0] insert_value;
	logic insert_busy;
	logic insert_done;
	logic insert_replaced;

	hash_table_pkg::bucket_entry_t model_table [`HT_DEPTH];
	logic [`HT_KEY_W-1:0] saved_key; // First key inserted, reused by later tests
	integer seed;
	int error_count;
	int check_count;

	hash_table_top u_hash_table_top (
		.clk(clk),
		.rst(rst),
		.lookup_req(lookup_req),
		.lookup_key(lookup_key),
		.lookup_busy(lookup_busy),
		.lookup_done(lookup_done),
		.lookup_hit(lookup_hit),
		.lookup_value(lookup_value),
		.insert_req(insert_req),
		.insert_key(insert_key),
		.insert_value(insert_value),
		.insert_busy(insert_busy),
		.insert_done(insert_done),
		.insert_replaced(insert_replaced)
	);

	always #(clk_period / 2) clk = ~clk;

	function automatic logic [`HT_IDX_W-1:0] h3_index(input logic [`HT_KEY_W-1:0] key);
		logic [`HT_IDX_W-1:0] acc;
		acc = '0;
		for (int i = 0; i < `HT_KEY_W; i++) begin
			if (key[i])
				acc = acc ^ h3_rows[i];
		end
		return acc;
	endfunction

	function automatic logic [`HT_KEY_W-1:0] random_key();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $random(seed);
		lo = $random(seed);
		return {hi, lo};
	endfunction

	function automatic logic [`HT_VAL_W-1:0] random_value();
		logic [31:0] r;
		r = $random(seed);
		return r[`HT_VAL_W-1:0];
	endfunction

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		check_count++;
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
			error_count++;
		end
	endtask

	task automatic lookup_wait(output int cycles);
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
		end while (!lookup_done);
	endtask

	task automatic insert_wait(output int cycles);
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
		end while (!insert_done);
	endtask

	task automatic lookup_and_check(input logic [`HT_KEY_W-1:0] key);
		hash_table_pkg::bucket_entry_t entry;
		logic exp_hit;
		int cycles;
		entry = model_table[h3_index(key)];
		exp_hit = entry.valid && (entry.key == key);
		lookup_key = key;
		lookup_req = 1'b1;
		@(posedge clk);
		#1;
		lookup_req = 1'b0;
		check_value("lookup_busy", lookup_busy, 1'b1);
		lookup_wait(cycles);
		check_value("lookup_latency", cycles, 3);
		check_value("lookup_hit", lookup_hit, exp_hit);
		check_value("lookup_value", lookup_value, exp_hit ? entry.value : 16'h0);
	endtask

	task automatic insert_and_check(input logic [`HT_KEY_W-1:0] key,
		input logic [`HT_VAL_W-1:0] value);
		logic [`HT_IDX_W-1:0] idx;
		logic exp_replaced;
		int cycles;
		idx = h3_index(key);
		exp_replaced = model_table[idx].valid && (model_table[idx].key != key);
		insert_key = key;
		insert_value = value;
		insert_req = 1'b1;
		@(posedge clk);
		#1;
		insert_req = 1'b0;
		check_value("insert_busy", insert_busy, 1'b1);
		insert_wait(cycles);
		check_value("insert_latency", cycles, 4);
		check_value("insert_replaced", insert_replaced, exp_replaced);
		model_table[idx] = {1'b1, key, value}; // Direct mapped, last write wins
	endtask

	task automatic check_reset_state();
		check_value("lookup_busy", lookup_busy, 1'b0);
		check_value("lookup_done", lookup_done, 1'b0);
		check_value("insert_busy", insert_busy, 1'b0);
		check_value("insert_done", insert_done, 1'b0);
		repeat (4) begin
			lookup_and_check(random_key());
			check_value("lookup_hit", lookup_hit, 1'b0);
		end
	endtask

	task automatic insert_then_lookup();
		logic [`HT_VAL_W-1:0] value;
		saved_key = random_key();
		value = random_value();
		insert_and_check(saved_key, value);
		check_value("insert_replaced", insert_replaced, 1'b0);
		lookup_and_check(saved_key);
		check_value("lookup_value", lookup_value, value);
	endtask

	task automatic reinsert_same_key();
		logic [`HT_VAL_W-1:0] value;
		value = random_value();
		insert_and_check(saved_key, value);
		check_value("insert_replaced", insert_replaced, 1'b0);
		lookup_and_check(saved_key);
		check_value("lookup_value", lookup_value, value);
	endtask

	task automatic bucket_collision();
		logic [`HT_KEY_W-1:0] key_a;
		logic [`HT_KEY_W-1:0] key_b;
		int tries;
		key_a = random_key();
		key_b = random_key();
		tries = 0;
		while ((h3_index(key_b) != h3_index(key_a) || key_b == key_a) && tries < max_tries) begin
			key_b = random_key();
			tries++;
		end
		if (tries == max_tries) begin
			$display("Error: no second key sharing a bucket with key %0h was found", key_a);
			error_count++;
		end else begin
			insert_and_check(key_a, random_value());
			insert_and_check(key_b, random_value());
			check_value("insert_replaced", insert_replaced, 1'b1);
			lookup_and_check(key_a);
			check_value("lookup_hit", lookup_hit, 1'b0);
			lookup_and_check(key_b);
			check_value("lookup_hit", lookup_hit, 1'b1);
		end
	endtask

	task automatic concurrent_ops();
		logic [`HT_KEY_W-1:0] ikey;
		logic [`HT_VAL_W-1:0] ivalue;
		logic [`HT_IDX_W-1:0] lidx;
		logic [`HT_IDX_W-1:0] iidx;
		hash_table_pkg::bucket_entry_t lentry;
		logic exp_hit;
		logic exp_replaced;
		int lk_cycles;
		int in_cycles;
		lidx = h3_index(saved_key);
		ikey = random_key();
		while (h3_index(ikey) == lidx)
			ikey = random_key();
		iidx = h3_index(ikey);
		ivalue = random_value();
		lentry = model_table[lidx];
		exp_hit = lentry.valid && (lentry.key == saved_key);
		exp_replaced = model_table[iidx].valid && (model_table[iidx].key != ikey);
		lookup_key = saved_key;
		insert_key = ikey;
		insert_value = ivalue;
		lookup_req = 1'b1;
		insert_req = 1'b1; // Same edge, so both units contend for the store
		@(posedge clk);
		#1;
		lookup_req = 1'b0;
		insert_req = 1'b0;
		fork
			lookup_wait(lk_cycles);
			insert_wait(in_cycles);
		join
		check_value("insert_latency", in_cycles, 4); // Wins the tie, lookup was served last
		check_value("lookup_latency", lk_cycles, 5); // Waits out the locked read and write
		check_value("lookup_hit", lookup_hit, exp_hit);
		check_value("lookup_value", lookup_value, exp_hit ? lentry.value : 16'h0);
		check_value("insert_replaced", insert_replaced, exp_replaced);
		model_table[iidx] = {1'b1, ikey, ivalue};
		lookup_and_check(ikey);
	endtask

	task automatic random_batch();
		logic [`HT_KEY_W-1:0] key_pool [8];
		logic [31:0] r;
		for (int i = 0; i < 8; i++)
			key_pool[i] = random_key();
		for (int n = 0; n < batch_ops; n++) begin
			r = $random(seed);
			if (r[0])
				insert_and_check(key_pool[r[3:1]], r[31:16]);
			else if (r[4])
				lookup_and_check(random_key()); // Mostly misses
			else
				lookup_and_check(key_pool[r[3:1]]);
		end
	endtask

	initial begin
		#(num_tests * cycles_per_test * clk_period);
		$display("Timeout: a done pulse never arrived within %0d cycles",
			num_tests * cycles_per_test);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		seed = 18;
		error_count = 0;
		check_count = 0;
		clk = 1'b0;
		rst = 1'b1;
		lookup_req = 1'b0;
		lookup_key = '0;
		insert_req = 1'b0;
		insert_key = '0;
		insert_value = '0;
		saved_key = '0;
		for (int i = 0; i < `HT_DEPTH; i++)
			model_table[i] = '0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		check_reset_state();
		insert_then_lookup();
		reinsert_same_key();
		bucket_collision();
		concurrent_ops();
		random_batch();

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/hash_table_properties.sv
`timescale 1ns/1ps
`default_nettype none

module hash_table_properties (
	input logic clk,
	input logic rst,
	input logic lk_req,
	input logic lk_grant,
	input logic in_req,
	input logic in_grant,
	input logic mem_we,
	input logic done
);

	a_grant_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(lk_grant && in_grant))
		else $error("lk_grant and in_grant are high together");

	a_lk_grant_needs_req: assert property (@(posedge clk) disable iff (rst)
		lk_grant |-> lk_req)
		else $error("lk_grant is high without lk_req");

	a_in_grant_needs_req: assert property (@(posedge clk) disable iff (rst)
		in_grant |-> in_req)
		else $error("in_grant is high without in_req");

	a_done_one_cycle: assert property (@(posedge clk) disable iff (rst)
		done |=> !done)
		else $error("done pulse lasted more than one cycle");

	a_no_write_on_lookup: assert property (@(posedge clk) disable iff (rst)
		lk_grant |-> !mem_we)
		else $error("mem_we is high while the lookup unit holds the grant");

endmodule

bind bucket_arbiter hash_table_properties u_arbiter_properties (
	.clk(clk),
	.rst(rst),
	.lk_req(lk_req),
	.lk_grant(lk_grant),
	.in_req(in_req),
	.in_grant(in_grant),
	.mem_we(mem_we),
	.done(1'b0)
);

bind lookup_unit hash_table_properties u_lookup_properties (
	.clk(clk),
	.rst(rst),
	.lk_req(lk_req),
	.lk_grant(lk_grant),
	.in_req(1'b0),
	.in_grant(1'b0),
	.mem_we(1'b0),
	.done(lookup_done)
);

bind insert_unit hash_table_properties u_insert_properties (
	.clk(clk),
	.rst(rst),
	.lk_req(1'b0),
	.lk_grant(1'b0),
	.in_req(in_req),
	.in_grant(in_grant),
	.mem_we(1'b0),
	.done(insert_done)
);

`default_nettype wire

//--- verilog/hash_table_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "hash_table_macros.svh"

module hash_table_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 lookup_req,
	input  logic [`HT_KEY_W-1:0] lookup_key,
	output logic                 lookup_busy,
	output logic                 lookup_done,
	output logic                 lookup_hit,
	output logic [`HT_VAL_W-1:0] lookup_value,
	input  logic                 insert_req,
	input  logic [`HT_KEY_W-1:0] insert_key,
	input  logic [`HT_VAL_W-1:0] insert_value,
	output logic                 insert_busy,
	output logic                 insert_done,
	output logic                 insert_replaced
);

	logic lk_req;
	logic lk_grant;
	logic [`HT_IDX_W-1:0] lk_addr;
	logic in_req;
	logic in_grant;
	logic in_we;
	logic [`HT_IDX_W-1:0] in_addr;
	hash_table_pkg::bucket_entry_t in_wdata;
	logic [`HT_IDX_W-1:0] mem_addr;
	logic mem_we;
	hash_table_pkg::bucket_entry_t mem_wdata;
	hash_table_pkg::bucket_entry_t rdata; // Shared by both units

	lookup_unit u_lookup_unit (
		.clk(clk),
		.rst(rst),
		.lookup_req(lookup_req),
		.lookup_key(lookup_key),
		.lookup_busy(lookup_busy),
		.lookup_done(lookup_done),
		.lookup_hit(lookup_hit),
		.lookup_value(lookup_value),
		.lk_req(lk_req),
		.lk_addr(lk_addr),
		.lk_grant(lk_grant),
		.rdata(rdata)
	);

	insert_unit u_insert_unit (
		.clk(clk),
		.rst(rst),
		.insert_req(insert_req),
		.insert_key(insert_key),
		.insert_value(insert_value),
		.insert_busy(insert_busy),
		.insert_done(insert_done),
		.insert_replaced(insert_replaced),
		.in_req(in_req),
		.in_addr(in_addr),
		.in_we(in_we),
		.in_wdata(in_wdata),
		.in_grant(in_grant),
		.rdata(rdata)
	);

	bucket_arbiter u_bucket_arbiter (
		.clk(clk),
		.rst(rst),
		.lk_req(lk_req),
		.lk_addr(lk_addr),
		.lk_grant(lk_grant),
		.in_req(in_req),
		.in_addr(in_addr),
		.in_we(in_we),
		.in_wdata(in_wdata),
		.in_grant(in_grant),
		.mem_addr(mem_addr),
		.mem_we(mem_we),
		.mem_wdata(mem_wdata)
	);

	bucket_ram u_bucket_ram (
		.clk(clk),
		.rst(rst),
		.mem_addr(mem_addr),
		.mem_we(mem_we),
		.mem_wdata(mem_wdata),
		.rdata(rdata)
	);

endmodule

`default_nettype wire

//--- verilog/insert_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "hash_table_macros.svh"

module insert_unit (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          insert_req,
	input  logic [`HT_KEY_W-1:0]          insert_key,
	input  logic [`HT_VAL_W-1:0]          insert_value,
	output logic                          insert_busy,
	output logic                          insert_done,
	output logic                          insert_replaced,
	output logic                          in_req,
	output logic [`HT_IDX_W-1:0]          in_addr,
	output logic                          in_we,
	output hash_table_pkg::bucket_entry_t in_wdata,
	input  logic                          in_grant,
	input  hash_table_pkg::bucket_entry_t rdata
);

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_HASH = 3'd1;
	localparam logic [2:0] S_READ = 3'd2;
	localparam logic [2:0] S_WRITE = 3'd3;
	localparam logic [2:0] S_FINISH = 3'd4;

	logic [2:0] state;
	logic [`HT_KEY_W-1:0] key_q;
	logic [`HT_VAL_W-1:0] value_q;
	logic accept;

	assign accept = insert_req && (state == S_IDLE);

	hash_h3 u_hash_h3 (
		.clk(clk),
		.rst(rst),
		.load(accept),
		.key(insert_key),
		.index(in_addr)
	);

	always_ff @(posedge clk) begin
		if (accept) begin
			key_q <= insert_key;
			value_q <= insert_value;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
			insert_done <= 1'b0;
			insert_replaced <= 1'b0;
		end else begin
			insert_done <= 1'b0;
			case (state)
				S_IDLE: if (accept) state <= S_HASH;
				S_HASH: state <= S_READ;
				S_READ: if (in_grant) state <= S_WRITE;
				S_WRITE: if (in_grant) begin
					// Old entry is on rdata while the write goes out
					insert_replaced <= rdata.valid && (rdata.key != key_q);
					state <= S_FINISH;
				end
				default: begin
					insert_done <= 1'b1;
					state <= S_IDLE;
				end
			endcase
		end
	end

	assign insert_busy = (state != S_IDLE);
	assign in_req = (state == S_READ) || (state == S_WRITE); // Lock spans read and write
	assign in_we = (state == S_WRITE);
	assign in_wdata = {1'b1, key_q, value_q};

endmodule

`default_nettype wire

//--- verilog/lookup_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "hash_table_macros.svh"

module lookup_unit (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          lookup_req,
	input  logic [`HT_KEY_W-1:0]          lookup_key,
	output logic                          lookup_busy,
	output logic                          lookup_done,
	output logic                          lookup_hit,
	output logic [`HT_VAL_W-1:0]          lookup_value,
	output logic                          lk_req,
	output logic [`HT_IDX_W-1:0]          lk_addr,
	input  logic                          lk_grant,
	input  hash_table_pkg::bucket_entry_t rdata
);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_HASH = 2'd1;
	localparam logic [1:0] S_REQ = 2'd2;
	localparam logic [1:0] S_CMP = 2'd3;

	logic [1:0] state;
	logic [`HT_KEY_W-1:0] key_q;
	logic accept;
	logic match;

	assign accept = lookup_req && (state == S_IDLE);
	assign match = rdata.valid && (rdata.key == key_q);

	hash_h3 u_hash_h3 (
		.clk(clk),
		.rst(rst),
		.load(accept),
		.key(lookup_key),
		.index(lk_addr)
	);

	always_ff @(posedge clk) begin
		if (accept)
			key_q <= lookup_key;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
			lookup_done <= 1'b0;
			lookup_hit <= 1'b0;
			lookup_value <= '0;
		end else begin
			lookup_done <= 1'b0;
			case (state)
				S_IDLE: if (accept) state <= S_HASH;
				S_HASH: state <= S_REQ; // Index settles here
				S_REQ: if (lk_grant) state <= S_CMP;
				default: begin
					lookup_done <= 1'b1;
					lookup_hit <= match;
					lookup_value <= match ? rdata.value : '0;
					state <= S_IDLE;
				end
			endcase
		end
	end

	assign lookup_busy = (state != S_IDLE);
	assign lk_req = (state == S_REQ);

endmodule

`default_nettype wire

//--- verilog/bucket_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "hash_table_macros.svh"

module bucket_arbiter (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          lk_req,
	input  logic [`HT_IDX_W-1:0]          lk_addr,
	output logic                          lk_grant,
	input  logic                          in_req,
	input  logic [`HT_IDX_W-1:0]          in_addr,
	input  logic                          in_we,
	input  hash_table_pkg::bucket_entry_t in_wdata,
	output logic                          in_grant,
	output logic [`HT_IDX_W-1:0]          mem_addr,
	output logic                          mem_we,
	output hash_table_pkg::bucket_entry_t mem_wdata
);

	logic owner_valid;
	logic owner_in; // Owner is the insert unit
	logic last_in; // Insert unit was served last

	always_comb begin
		lk_grant = 1'b0;
		in_grant = 1'b0;
		if (owner_valid && owner_in && in_req)
			in_grant = 1'b1; // Lock held by insert
		else if (owner_valid && !owner_in && lk_req)
			lk_grant = 1'b1;
		else if (lk_req && in_req) begin
			if (last_in)
				lk_grant = 1'b1;
			else
				in_grant = 1'b1;
		end else if (lk_req)
			lk_grant = 1'b1;
		else if (in_req)
			in_grant = 1'b1;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			owner_valid <= 1'b0;
			owner_in <= 1'b0;
			last_in <= 1'b0;
		end else begin
			owner_valid <= lk_grant | in_grant;
			owner_in <= in_grant;
			if (lk_grant | in_grant)
				last_in <= in_grant;
		end
	end

	assign mem_addr = in_grant ? in_addr : lk_addr;
	assign mem_we = in_grant & in_we; // Lookups only read
	assign mem_wdata = in_wdata;

endmodule

`default_nettype wire

//--- verilog/bucket_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "hash_table_macros.svh"

module bucket_ram (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [`HT_IDX_W-1:0]          mem_addr,
	input  logic                          mem_we,
	input  hash_table_pkg::bucket_entry_t mem_wdata,
	output hash_table_pkg::bucket_entry_t rdata
);

	logic [`HT_KEY_W+`HT_VAL_W-1:0] payload [`HT_DEPTH];
	logic [`HT_DEPTH-1:0] valid_bits;
	logic [`HT_KEY_W+`HT_VAL_W-1:0] rd_payload;
	logic rd_valid;

	always_ff @(posedge clk) begin
		if (mem_we)
			payload[mem_addr] <= {mem_wdata.key, mem_wdata.value};
		rd_payload <= payload[mem_addr]; // Read first on a write
	end

	// Per-bucket valid flags
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_bits <= '0;
			rd_valid <= 1'b0;
		end else begin
			if (mem_we)
				valid_bits[mem_addr] <= mem_wdata.valid;
			rd_valid <= valid_bits[mem_addr];
		end
	end

	assign rdata = {rd_valid, rd_payload};

endmodule

`default_nettype wire

//--- verilog/hash_h3.sv
`timescale 1ns/1ps
`default_nettype none

`include "hash_table_macros.svh"

module hash_h3 (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 load,
	input  logic [`HT_KEY_W-1:0] key,
	output logic [`HT_IDX_W-1:0] index
);

	// Row i is folded in when key bit i is set
	localparam logic [`HT_IDX_W-1:0] H3_ROWS [`HT_KEY_W] = '{
		10'b0110110101,
		10'b0000100000,
		10'b0101101001,
		10'b0001001100,
		10'b1001011101,
		10'b0101000110,
		10'b1100110001,
		10'b1001111011,
		10'b0010110110,
		10'b1101111111,
		10'b1110101100,
		10'b0001011101,
		10'b0111110010,
		10'b1011111001,
		10'b0011011101,
		10'b1001001010,
		10'b1011000000,
		10'b1010100010,
		10'b0110101110,
		10'b1100001111,
		10'b1000011011,
		10'b1010100001,
		10'b0001110110,
		10'b1111111100,
		10'b0111110000,
		10'b1010011111,
		10'b0011010010,
		10'b0011110110,
		10'b0011110000,
		10'b0110010001,
		10'b0111111101,
		10'b0011000001,
		10'b0001101101,
		10'b0011010010,
		10'b0110001001,
		10'b0100100010,
		10'b0111110100,
		10'b1010011001,
		10'b0010101000,
		10'b0100001100,
		10'b1001111000,
		10'b0011001001,
		10'b1010111011,
		10'b1110101000,
		10'b1101010010,
		10'b1011110001,
		10'b1000101000,
		10'b0010111010,
		10'b1100101100,
		10'b1010001000,
		10'b1000000111,
		10'b0001100001,
		10'b0000001110,
		10'b1101010001,
		10'b1001001011,
		10'b0001000010,
		10'b0010111000,
		10'b0000001000,
		10'b1000010001,
		10'b0001111000,
		10'b0101101000,
		10'b0010101001,
		10'b1110101100,
		10'b0010000001
	};

	logic [`HT_IDX_W-1:0] hash_next;

	always_comb begin
		hash_next = '0;
		for (int i = 0; i < `HT_KEY_W; i++) begin
			if (key[i])
				hash_next = hash_next ^ H3_ROWS[i];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			index <= '0;
		else if (load)
			index <= hash_next; // Held until the next load
	end

endmodule

`default_nettype wire

//--- verilog/hash_table_pkg.sv
`default_nettype none

`include "hash_table_macros.svh"

package hash_table_pkg;

	typedef struct packed {
		logic valid;
		logic [`HT_KEY_W-1:0] key;
		logic [`HT_VAL_W-1:0] value;
	} bucket_entry_t;

endpackage

`default_nettype wire

//--- verilog/hash_table_macros.svh
`ifndef HASH_TABLE_MACROS_SVH
`define HASH_TABLE_MACROS_SVH

// Key and value widths of one table entry
`define HT_KEY_W 64
`define HT_VAL_W 16

// Bucket index width and bucket count, kept consistent
`define HT_IDX_W 10
`define HT_DEPTH 1024

`endif
